/* rtl/poly_consts.svh */
`ifndef POLY_CONSTS_SVH
`define POLY_CONSTS_SVH

// Polynomial shape and modulus
`define POLY_N      64
`define POLY_Q      12289
`define COEF_W      14
`define IDX_W       6

// APB bus widths
`define APB_AW      12
`define APB_DW      32

// Register offsets and window bases
`define REG_CTRL    12'h000
`define REG_STATUS  12'h004
`define WIN_A       12'h100
`define WIN_B       12'h200

// Read, operate, reduce and write
`define ARITH_LAT   3

`endif

/* rtl/poly_pkg.sv */
`default_nettype none

`include "poly_consts.svh"

package poly_pkg;

    // Value 3 is reserved and rejected by the register block
    typedef enum logic [1:0] {
        OP_ADD = 2'd0,
        OP_SUB = 2'd1,
        OP_MUL = 2'd2
    } op_t;

    typedef enum logic [1:0] {
        IDLE,
        RUN,
        DRAIN
    } arith_state_t;

    typedef logic [`COEF_W-1:0] coef_t;

endpackage

`default_nettype wire

/* rtl/coef_ram.sv */
`timescale 1ns/1ps
`default_nettype none

`include "poly_consts.svh"

module coef_ram (
    input  logic                clk,
    input  logic                we,
    input  logic [`IDX_W-1:0]   waddr,
    input  poly_pkg::coef_t     wdata,
    input  logic [`IDX_W-1:0]   raddr,
    output poly_pkg::coef_t     rdata
);

    poly_pkg::coef_t mem [`POLY_N];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

    // Registered read, old data on a same-address collision
    always_ff @(posedge clk) begin
        rdata <= mem[raddr];
    end

endmodule

`default_nettype wire

/* rtl/poly_arith.sv */
`timescale 1ns/1ps
`default_nettype none

`include "poly_consts.svh"

module poly_arith (
    input  logic                clk,
    input  logic                rst,
    input  logic                start,
    input  poly_pkg::op_t       op,
    input  poly_pkg::coef_t     a_data,
    input  poly_pkg::coef_t     b_data,
    output logic                busy,
    output logic                done,
    output logic [`IDX_W-1:0]   rd_idx,
    output logic                wr_en,
    output logic [`IDX_W-1:0]   wr_idx,
    output poly_pkg::coef_t     wr_data
);

    localparam int PROD_W = 2 * `COEF_W;
    localparam logic [`IDX_W-1:0]  LAST_IDX = `IDX_W'(`POLY_N - 1);
    localparam logic [`COEF_W:0]   Q_EXT    = `POLY_Q;
    localparam logic [PROD_W-1:0]  Q_PROD   = `POLY_Q;

    poly_pkg::arith_state_t state;
    poly_pkg::op_t          op_r;
    logic [`IDX_W-1:0]      cnt;
    logic                   issue;

    logic                   v1, last1;
    logic [`IDX_W-1:0]      idx1;
    logic                   v2, last2;
    logic [`IDX_W-1:0]      idx2;
    logic [PROD_W-1:0]      res2;

    logic [`COEF_W:0]       sum, sum_red, diff, diff_fix;
    logic [PROD_W-1:0]      prod, res_next, prod_mod;

    ////////////////////////////////////////////////////////////////////////////
    // Control FSM

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= poly_pkg::IDLE;
            op_r  <= poly_pkg::OP_ADD;
            cnt   <= '0;
        end else begin
            case (state)
                poly_pkg::IDLE: begin
                    if (start) begin
                        state <= poly_pkg::RUN;
                        op_r  <= op;
                        cnt   <= '0;
                    end
                end
                poly_pkg::RUN: begin
                    if (cnt == LAST_IDX) begin
                        state <= poly_pkg::DRAIN;
                    end
                    cnt <= cnt + 1'b1;
                end
                poly_pkg::DRAIN: begin
                    // Last write leaves with done
                    if (done) begin
                        state <= poly_pkg::IDLE;
                    end
                end
                default: state <= poly_pkg::IDLE;
            endcase
        end
    end

    assign issue  = (state == poly_pkg::RUN);
    assign busy   = (state != poly_pkg::IDLE);
    assign rd_idx = cnt;

    ////////////////////////////////////////////////////////////////////////////
    // Operate stage

    assign sum      = {1'b0, a_data} + {1'b0, b_data};
    assign sum_red  = (sum >= Q_EXT) ? sum - Q_EXT : sum;
    assign diff     = {1'b0, a_data} - {1'b0, b_data};
    // Top bit is the borrow of a - b
    assign diff_fix = diff[`COEF_W] ? diff + Q_EXT : diff;
    assign prod     = a_data * b_data;

    always_comb begin
        case (op_r)
            poly_pkg::OP_ADD: res_next = {{`COEF_W{1'b0}}, sum_red[`COEF_W-1:0]};
            poly_pkg::OP_SUB: res_next = {{`COEF_W{1'b0}}, diff_fix[`COEF_W-1:0]};
            default:          res_next = prod;
        endcase
    end

    assign prod_mod = res2 % Q_PROD;

    ////////////////////////////////////////////////////////////////////////////
    // Pipeline registers

    always_ff @(posedge clk) begin
        if (rst) begin
            v1    <= 1'b0;
            last1 <= 1'b0;
            v2    <= 1'b0;
            last2 <= 1'b0;
            wr_en <= 1'b0;
            done  <= 1'b0;
        end else begin
            v1    <= issue;
            last1 <= issue && (cnt == LAST_IDX);
            v2    <= v1;
            last2 <= last1;
            wr_en <= v2;
            done  <= last2;
        end
    end

    always_ff @(posedge clk) begin
        idx1   <= cnt;
        idx2   <= idx1;
        res2   <= res_next;
        wr_idx <= idx2;
        if (op_r == poly_pkg::OP_MUL) begin
            wr_data <= prod_mod[`COEF_W-1:0];
        end else begin
            wr_data <= res2[`COEF_W-1:0];
        end
    end

endmodule

`default_nettype wire

/* rtl/poly_regs.sv */
`timescale 1ns/1ps
`default_nettype none

`include "poly_consts.svh"

module poly_regs (
    input  logic                clk,
    input  logic                rst,
    input  logic [`APB_AW-1:0]  paddr,
    input  logic                psel,
    input  logic                penable,
    input  logic                pwrite,
    input  logic [`APB_DW-1:0]  pwdata,
    output logic [`APB_DW-1:0]  prdata,
    output logic                pready,
    output logic                pslverr,
    output logic                start,
    output poly_pkg::op_t       op,
    input  logic                busy,
    input  logic                done,
    input  logic [`IDX_W-1:0]   rd_idx,
    input  logic                wr_en,
    input  logic [`IDX_W-1:0]   wr_idx,
    input  poly_pkg::coef_t     wr_data,
    output logic                a_we,
    output logic [`IDX_W-1:0]   a_waddr,
    output poly_pkg::coef_t     a_wdata,
    output logic [`IDX_W-1:0]   a_raddr,
    input  poly_pkg::coef_t     a_rdata,
    output logic                b_we,
    output logic [`IDX_W-1:0]   b_waddr,
    output poly_pkg::coef_t     b_wdata,
    output logic [`IDX_W-1:0]   b_raddr,
    input  poly_pkg::coef_t     b_rdata
);

    localparam int WIN_LSB = `IDX_W + 2;

    logic               access;
    logic               is_ctrl, is_status, is_win_a, is_win_b, is_win;
    logic               bad;
    logic               rd_wait;
    logic               done_flag;
    logic               ctrl_wr;
    logic               host_wr_a, host_wr_b;
    logic [`IDX_W-1:0]  host_idx;
    logic [`APB_AW-1:0] win_base;

    ////////////////////////////////////////////////////////////////////////////
    // Address decode

    assign access    = psel && penable;
    assign host_idx  = paddr[WIN_LSB-1:2];
    assign win_base  = {paddr[`APB_AW-1:WIN_LSB], {WIN_LSB{1'b0}}};
    assign is_ctrl   = (paddr == `REG_CTRL);
    assign is_status = (paddr == `REG_STATUS);
    assign is_win_a  = (win_base == `WIN_A) && (paddr[1:0] == 2'b00);
    assign is_win_b  = (win_base == `WIN_B) && (paddr[1:0] == 2'b00);
    assign is_win    = is_win_a || is_win_b;

    always_comb begin
        bad = 1'b1;
        if (is_ctrl) begin
            bad = pwrite && (busy || pwdata[1:0] == 2'd3);
        end else if (is_status) begin
            bad = pwrite;
        end else if (is_win) begin
            bad = busy;
        end
    end

    // Good window reads wait one cycle for the RAM
    assign pready  = access && !(is_win && !pwrite && !bad && !rd_wait);
    assign pslverr = pready && bad;

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_wait <= 1'b0;
        end else begin
            rd_wait <= access && !pready;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Control and status

    assign ctrl_wr = access && is_ctrl && pwrite && !bad;

    always_ff @(posedge clk) begin
        if (rst) begin
            op        <= poly_pkg::OP_ADD;
            start     <= 1'b0;
            done_flag <= 1'b0;
        end else begin
            start <= ctrl_wr && pwdata[8];
            if (ctrl_wr) begin
                op <= poly_pkg::op_t'(pwdata[1:0]);
            end
            if (start) begin
                done_flag <= 1'b0;
            end else if (done) begin
                done_flag <= 1'b1;
            end
        end
    end

    always_comb begin
        prdata = '0;
        if (access && !bad && !pwrite) begin
            if (is_ctrl) begin
                prdata[1:0] = op;
            end else if (is_status) begin
                prdata[1:0] = {done_flag, busy};
            end else if (is_win_a) begin
                prdata[`COEF_W-1:0] = a_rdata;
            end else if (is_win_b) begin
                prdata[`COEF_W-1:0] = b_rdata;
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Memory ports, engine owns them while busy

    assign host_wr_a = access && is_win_a && pwrite && !bad;
    assign host_wr_b = access && is_win_b && pwrite && !bad;

    assign a_we    = busy ? wr_en   : host_wr_a;
    assign a_waddr = busy ? wr_idx  : host_idx;
    assign a_wdata = busy ? wr_data : pwdata[`COEF_W-1:0];
    assign a_raddr = busy ? rd_idx  : host_idx;

    // B is read-only for the engine
    assign b_we    = host_wr_b;
    assign b_waddr = host_idx;
    assign b_wdata = pwdata[`COEF_W-1:0];
    assign b_raddr = busy ? rd_idx : host_idx;

endmodule

`default_nettype wire

/* rtl/poly_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "poly_consts.svh"

module poly_top (
    input  logic                clk,
    input  logic                rst,
    input  logic [`APB_AW-1:0]  paddr,
    input  logic                psel,
    input  logic                penable,
    input  logic                pwrite,
    input  logic [`APB_DW-1:0]  pwdata,
    output logic [`APB_DW-1:0]  prdata,
    output logic                pready,
    output logic                pslverr,
    output logic                done
);

    logic               start;
    poly_pkg::op_t      op;
    logic               busy;
    logic [`IDX_W-1:0]  rd_idx;
    logic               wr_en;
    logic [`IDX_W-1:0]  wr_idx;
    poly_pkg::coef_t    wr_data;

    logic               a_we, b_we;
    logic [`IDX_W-1:0]  a_waddr, a_raddr, b_waddr, b_raddr;
    poly_pkg::coef_t    a_wdata, a_rdata, b_wdata, b_rdata;

    poly_regs regs0 (
        .clk(clk), .rst(rst),
        .paddr(paddr), .psel(psel), .penable(penable), .pwrite(pwrite),
        .pwdata(pwdata), .prdata(prdata), .pready(pready), .pslverr(pslverr),
        .start(start), .op(op), .busy(busy), .done(done),
        .rd_idx(rd_idx), .wr_en(wr_en), .wr_idx(wr_idx), .wr_data(wr_data),
        .a_we(a_we), .a_waddr(a_waddr), .a_wdata(a_wdata),
        .a_raddr(a_raddr), .a_rdata(a_rdata),
        .b_we(b_we), .b_waddr(b_waddr), .b_wdata(b_wdata),
        .b_raddr(b_raddr), .b_rdata(b_rdata)
    );

    poly_arith arith0 (
        .clk(clk), .rst(rst), .start(start), .op(op),
        .a_data(a_rdata), .b_data(b_rdata),
        .busy(busy), .done(done), .rd_idx(rd_idx),
        .wr_en(wr_en), .wr_idx(wr_idx), .wr_data(wr_data)
    );

    // Polynomial A, result written back in place
    coef_ram ram_a (
        .clk(clk), .we(a_we), .waddr(a_waddr), .wdata(a_wdata),
        .raddr(a_raddr), .rdata(a_rdata)
    );

    coef_ram ram_b (
        .clk(clk), .we(b_we), .waddr(b_waddr), .wdata(b_wdata),
        .raddr(b_raddr), .rdata(b_rdata)
    );

endmodule

`default_nettype wire

/* tb/poly_top_chk.sv */
`timescale 1ns/1ps
`default_nettype none

module poly_top_chk (
    input logic clk,
    input logic rst,
    input logic psel,
    input logic penable,
    input logic pready,
    input logic done,
    input logic busy,
    input logic wr_en
);

    int err_count = 0;

    // One wait state at most, window reads only
    pready_wait: assert property (@(posedge clk) disable iff (rst)
        psel && penable && !pready |=> pready)
        else begin
            err_count++;
            $error("pready still low in the second access cycle");
        end

    done_in_busy: assert property (@(posedge clk) disable iff (rst)
        done |-> busy)
        else begin
            err_count++;
            $error("done pulse outside of an operation");
        end

    write_in_busy: assert property (@(posedge clk) disable iff (rst)
        wr_en |-> busy)
        else begin
            err_count++;
            $error("engine write outside of an operation");
        end

    // Busy ends exactly one cycle after done
    busy_after_done: assert property (@(posedge clk) disable iff (rst)
        done |=> !busy)
        else begin
            err_count++;
            $error("busy still high after done");
        end

    busy_fall: assert property (@(posedge clk) disable iff (rst)
        $fell(busy) |-> $past(done))
        else begin
            err_count++;
            $error("busy fell without a done pulse");
        end

endmodule

bind poly_top poly_top_chk chk0 (
    .clk(clk), .rst(rst), .psel(psel), .penable(penable), .pready(pready),
    .done(done), .busy(busy), .wr_en(wr_en)
);

`default_nettype wire

/* tb/poly_top_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "poly_consts.svh"

module poly_top_tb;

    localparam int WATCHDOG_CYCLES = 4 * (`POLY_N * 2 * 4 + `POLY_N + 20) + 1000;

    logic               clk;
    logic               rst;
    logic [`APB_AW-1:0] paddr;
    logic               psel;
    logic               penable;
    logic               pwrite;
    logic [`APB_DW-1:0] pwdata;
    logic [`APB_DW-1:0] prdata;
    logic               pready;
    logic               pslverr;
    logic               done;

    int          sh_a [`POLY_N];
    int          sh_b [`POLY_N];
    logic [15:0] lfsr = 16'd94;
    int          mismatch_count = 0;
    int          fail_count = 0;
    int          done_count = 0;
    int          done_base = 0;
    int          cycle = 0;
    int          done_cycle = 0;
    int          access_cycle = 0;
    int          start_cycle = 0;

    poly_top dut0 (
        .clk(clk), .rst(rst), .paddr(paddr), .psel(psel), .penable(penable),
        .pwrite(pwrite), .pwdata(pwdata), .prdata(prdata), .pready(pready),
        .pslverr(pslverr), .done(done)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    // Done pulses, sampled mid-cycle
    always @(negedge clk) begin
        if (done) begin
            done_count++;
            done_cycle = cycle;
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Watchdog expired after %0d cycles, the run did not finish", WATCHDOG_CYCLES);
        $display("Errors: %0d mismatches, %0d other failures, %0d assertion failures",
                 mismatch_count, fail_count, dut0.chk0.err_count);
        $display("CHECKS FAILED");
        $finish;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Helpers

    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic random_coef(output int c);
        logic [`COEF_W-1:0] bits;
        int k;
        bits = '0;
        for (k = 0; k < `COEF_W; k++) begin
            lfsr = lfsr_step(lfsr);
            bits = {bits[`COEF_W-2:0], lfsr[0]};
        end
        c = int'(bits) % `POLY_Q;
    endtask

    function automatic int expected_coef(input poly_pkg::op_t op, input int a, input int b);
        case (op)
            poly_pkg::OP_ADD: return (a + b) % `POLY_Q;
            poly_pkg::OP_SUB: return (a - b + `POLY_Q) % `POLY_Q;
            default:          return (a * b) % `POLY_Q;
        endcase
    endfunction

    function automatic logic [`APB_AW-1:0] coef_addr(input logic [`APB_AW-1:0] base,
                                                     input int i);
        return base + `APB_AW'(4 * i);
    endfunction

    task automatic expect_eq(input int got, input int exp, input string what);
        assert (got == exp) else begin
            mismatch_count++;
            $display("MISMATCH at %0t: %s got %0d expected %0d", $time, what, got, exp);
        end
    endtask

    // Setup then access; inputs change 1 ns after the edge
    task automatic bus_transfer(input logic wr, input logic [`APB_AW-1:0] addr,
                                input logic [`APB_DW-1:0] wdata,
                                output logic [`APB_DW-1:0] rdata, output logic err);
        int waits;
        waits   = 0;
        paddr   = addr;
        pwrite  = wr;
        pwdata  = wdata;
        psel    = 1'b1;
        penable = 1'b0;
        @(posedge clk);
        #1;
        penable = 1'b1;
        @(negedge clk);
        while (!pready && waits < 4) begin
            waits++;
            @(negedge clk);
        end
        if (!pready) begin
            fail_count++;
            $display("No pready after %0d wait states at address %h", waits, addr);
        end
        rdata        = prdata;
        err          = pslverr;
        access_cycle = cycle;
        @(posedge clk);
        #1;
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic write_word(input logic [`APB_AW-1:0] addr, input logic [`APB_DW-1:0] data,
                              output logic err);
        logic [`APB_DW-1:0] unused;
        bus_transfer(1'b1, addr, data, unused, err);
    endtask

    task automatic read_word(input logic [`APB_AW-1:0] addr, output logic [`APB_DW-1:0] data,
                             output logic err);
        bus_transfer(1'b0, addr, '0, data, err);
    endtask

    task automatic load_polys();
        logic err;
        int i;
        for (i = 0; i < `POLY_N; i++) begin
            random_coef(sh_a[i]);
            random_coef(sh_b[i]);
            write_word(coef_addr(`WIN_A, i), sh_a[i], err);
            expect_eq(err, 0, "pslverr on A write");
            write_word(coef_addr(`WIN_B, i), sh_b[i], err);
            expect_eq(err, 0, "pslverr on B write");
        end
    endtask

    task automatic compare_windows();
        logic [`APB_DW-1:0] rd;
        logic err;
        int i;
        for (i = 0; i < `POLY_N; i++) begin
            read_word(coef_addr(`WIN_A, i), rd, err);
            expect_eq(rd, sh_a[i], $sformatf("A[%0d] readback", i));
            read_word(coef_addr(`WIN_B, i), rd, err);
            expect_eq(rd, sh_b[i], $sformatf("B[%0d] readback", i));
            expect_eq(err, 0, "pslverr on window read");
        end
    endtask

    task automatic start_op(input poly_pkg::op_t op);
        logic err;
        done_base = done_count;
        write_word(`REG_CTRL, {23'd0, 1'b1, 6'd0, op}, err);
        start_cycle = access_cycle;
        expect_eq(err, 0, "pslverr on start");
    endtask

    // Poll until idle, then check timing, status and every result
    task automatic finish_op(input poly_pkg::op_t op);
        logic [`APB_DW-1:0] rd;
        logic err;
        int polls;
        int i;
        polls = 0;
        rd    = 32'h1;
        while (rd[0] && polls < 100) begin
            read_word(`REG_STATUS, rd, err);
            polls++;
        end
        if (rd[0]) begin
            fail_count++;
            $display("Timeout while polling busy in STATUS after %0d reads", polls);
        end
        expect_eq(rd, 2, "STATUS after operation");
        expect_eq(done_count - done_base, 1, "done pulses for one operation");
        expect_eq(done_cycle - start_cycle, `POLY_N + `ARITH_LAT + 1, "cycles start to done");
        for (i = 0; i < `POLY_N; i++) begin
            read_word(coef_addr(`WIN_A, i), rd, err);
            sh_a[i] = expected_coef(op, sh_a[i], sh_b[i]);
            expect_eq(rd, sh_a[i], $sformatf("result A[%0d] of op %0d", i, op));
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Main sequence

    initial begin
        logic [`APB_DW-1:0] rd;
        logic err;
        int k;
        rst     = 1'b1;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = '0;
        pwdata  = '0;
        repeat (8) @(posedge clk);
        #1;
        rst = 1'b0;

        read_word(`REG_STATUS, rd, err);
        expect_eq(rd, 0, "STATUS after reset");
        read_word(`REG_CTRL, rd, err);
        expect_eq(rd, 0, "CTRL after reset");
        // Upper bits set, start clear
        for (k = 2; k >= 0; k--) begin
            write_word(`REG_CTRL, 32'hFFFF_FE00 | k, err);
            read_word(`REG_CTRL, rd, err);
            expect_eq(rd, k, "CTRL op readback");
        end

        load_polys();
        // Index 0 at q - 1 on both sides so the add wraps
        sh_a[0] = `POLY_Q - 1;
        sh_b[0] = `POLY_Q - 1;
        write_word(`WIN_A, sh_a[0], err);
        write_word(`WIN_B, sh_b[0], err);
        compare_windows();
        start_op(poly_pkg::OP_ADD);
        finish_op(poly_pkg::OP_ADD);

        load_polys();
        start_op(poly_pkg::OP_SUB);
        finish_op(poly_pkg::OP_SUB);

        load_polys();
        start_op(poly_pkg::OP_MUL);
        finish_op(poly_pkg::OP_MUL);

        // Reserved op is refused
        write_word(`REG_CTRL, 32'h103, err);
        expect_eq(err, 1, "pslverr on op 3");
        read_word(`REG_STATUS, rd, err);
        expect_eq(rd, 2, "STATUS after refused start");
        read_word(`REG_CTRL, rd, err);
        expect_eq(rd, 2, "CTRL after refused write");

        // Accesses while busy are refused
        start_op(poly_pkg::OP_ADD);
        write_word(coef_addr(`WIN_A, 5), 32'h1234, err);
        expect_eq(err, 1, "pslverr on window write while busy");
        write_word(`REG_CTRL, 32'h101, err);
        expect_eq(err, 1, "pslverr on CTRL write while busy");
        read_word(coef_addr(`WIN_B, 0), rd, err);
        expect_eq(err, 1, "pslverr on window read while busy");
        expect_eq(rd, 0, "window read data while busy");
        finish_op(poly_pkg::OP_ADD);
        read_word(`REG_CTRL, rd, err);
        expect_eq(rd, 0, "CTRL after refused busy write");

        $display("Errors: %0d mismatches, %0d other failures, %0d assertion failures",
                 mismatch_count, fail_count, dut0.chk0.err_count);
        if (mismatch_count == 0 && fail_count == 0 && dut0.chk0.err_count == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* poly_top.f */
+incdir+rtl
rtl/poly_pkg.sv
rtl/coef_ram.sv
rtl/poly_arith.sv
rtl/poly_regs.sv
rtl/poly_top.sv
tb/poly_top_chk.sv
tb/poly_top_tb.sv

/* Makefile */
# Verilator build and run for the polynomial arithmetic unit

VERILATOR ?= verilator
TOP       ?= poly_top_tb
FLIST     ?= poly_top.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

PASS_MSG  := ALL CHECKS PASSED
FAIL_MSG  := CHECKS FAILED

SRCS := $(shell grep -v '^+' $(FLIST))
HDRS := rtl/poly_consts.svh
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(FLIST) $(SRCS) $(HDRS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FLIST)

run: $(BIN)
	$(BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation failed, see $(LOG)"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "No result in $(LOG)"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
